// File: Bender.yml
package:
  name: csr_file

sources:
  # RTL in compile order, package first
  - source/csr_pkg.sv
  - source/csr_access_decode.sv
  - source/csr_counter_bank.sv
  - source/csr_trap_bank.sv
  - source/csr_response.sv
  - source/csr_file.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/csr_file_assertions.sv
      - verification/csr_file_tb.sv

// File: list.f
source/csr_pkg.sv
source/csr_access_decode.sv
source/csr_counter_bank.sv
source/csr_trap_bank.sv
source/csr_response.sv
source/csr_file.sv
verification/csr_file_assertions.sv
verification/csr_file_tb.sv

// File: source/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode (
    input  csr_pkg::t_csr_inst              inst,
    input  logic [csr_pkg::xlen-1:0]        write_data,
    output csr_pkg::t_csr_write_req         write_req
);
    import csr_pkg::*;

    // ==================================================
    // Operand select and write filter
    // ==================================================
    logic            ro_space;
    logic [xlen-1:0] operand;

    // Access field 11 marks the read-only CSR range
    assign ro_space = (inst.addr.fields.access == csr_access_ro);

    // Immediate form (csrrwi and friends) or register form
    assign operand = inst.imm_sel ? inst.imm : write_data;

    always_comb begin
        write_req.en      = inst.wren && !ro_space;
        write_req.op      = inst.op;
        write_req.addr    = inst.addr.raw;
        write_req.operand = operand;
    end

endmodule

// File: source/csr_counter_bank.sv
`timescale 1ns/1ps

module csr_counter_bank (
    input  logic                            clk,
    input  logic                            rst,
    input  csr_pkg::t_csr_write_req         write_req,
    input  logic [csr_pkg::csr_addr_w-1:0]  read_addr,
    input  logic                            instret_valid,
    output csr_pkg::t_csr_read_rsp          read_rsp
);
    import csr_pkg::*;

    logic [2*xlen-1:0] mcycle_q;
    logic [2*xlen-1:0] mcycle_d;
    logic [2*xlen-1:0] minstret_q;
    logic [2*xlen-1:0] minstret_d;

    logic wr_mcycle;
    logic wr_mcycleh;
    logic wr_minstret;
    logic wr_minstreth;

    // Next value of one 64-bit counter
    // A software access to a half replaces the increment for that half
    function automatic logic [2*xlen-1:0] count_next(
        input logic [2*xlen-1:0] cur,
        input logic              inc,
        input logic              wr_lo,
        input logic              wr_hi,
        input logic [1:0]        op,
        input logic [xlen-1:0]   operand
    );
        logic [xlen-1:0] lo;
        logic [xlen-1:0] hi;
        logic            carry;
        {carry, lo} = {1'b0, cur[xlen-1:0]} + {{xlen{1'b0}}, inc};
        if (wr_lo) begin
            lo    = csr_apply(op, cur[xlen-1:0], operand);
            carry = 1'b0;
        end
        if (wr_hi) begin
            hi = csr_apply(op, cur[2*xlen-1:xlen], operand);
        end else begin
            hi = cur[2*xlen-1:xlen] + {{(xlen-1){1'b0}}, carry};
        end
        return {hi, lo};
    endfunction

    // ==================================================
    // Write hits
    // ==================================================
    assign wr_mcycle    = write_req.en && (write_req.addr == csr_mcycle);
    assign wr_mcycleh   = write_req.en && (write_req.addr == csr_mcycleh);
    assign wr_minstret  = write_req.en && (write_req.addr == csr_minstret);
    assign wr_minstreth = write_req.en && (write_req.addr == csr_minstreth);

    // mcycle runs every clock, minstret on retire only
    assign mcycle_d   = count_next(mcycle_q, 1'b1, wr_mcycle, wr_mcycleh,
                                   write_req.op, write_req.operand);
    assign minstret_d = count_next(minstret_q, instret_valid, wr_minstret, wr_minstreth,
                                   write_req.op, write_req.operand);

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= mcycle_d;
            minstret_q <= minstret_d;
        end
    end

    // ==================================================
    // Read port
    // ==================================================
    always_comb begin
        read_rsp.hit = 1'b1;
        case (read_addr)
            csr_mcycle:    read_rsp.data = mcycle_q[xlen-1:0];
            csr_mcycleh:   read_rsp.data = mcycle_q[2*xlen-1:xlen];
            csr_minstret:  read_rsp.data = minstret_q[xlen-1:0];
            csr_minstreth: read_rsp.data = minstret_q[2*xlen-1:xlen];
            default: begin
                read_rsp.hit  = 1'b0;
                read_rsp.data = '0;
            end
        endcase
    end

endmodule

// File: source/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                            clk,
    input  logic                            rst,
    input  csr_pkg::t_csr_inst              csr_inst,
    input  logic [csr_pkg::xlen-1:0]        write_data,
    input  logic [csr_pkg::xlen-1:0]        pc,
    input  csr_pkg::t_trap_event            trap,
    input  logic                            instret_valid,
    output logic [csr_pkg::xlen-1:0]        read_data,
    output csr_pkg::t_pc_update             pc_update
);
    import csr_pkg::*;

    t_csr_write_req write_req;
    t_csr_read_rsp  counter_rsp;
    t_csr_read_rsp  trap_rsp;
    t_trap_vectors  vectors;

    csr_access_decode i_csr_access_decode (
        .inst       (csr_inst),
        .write_data (write_data),
        .write_req  (write_req)
    );

    // ==================================================
    // Register banks
    // ==================================================
    csr_counter_bank i_csr_counter_bank (
        .clk           (clk),
        .rst           (rst),
        .write_req     (write_req),
        .read_addr     (csr_inst.addr.raw),
        .instret_valid (instret_valid),
        .read_rsp      (counter_rsp)
    );

    csr_trap_bank i_csr_trap_bank (
        .clk       (clk),
        .rst       (rst),
        .write_req (write_req),
        .read_addr (csr_inst.addr.raw),
        .pc        (pc),
        .trap      (trap),
        .read_rsp  (trap_rsp),
        .vectors   (vectors)
    );

    csr_response i_csr_response (
        .rden        (csr_inst.rden),
        .counter_rsp (counter_rsp),
        .trap_rsp    (trap_rsp),
        .trap        (trap),
        .vectors     (vectors),
        .read_data   (read_data),
        .pc_update   (pc_update)
    );

endmodule

// File: source/csr_pkg.sv
package csr_pkg;

    // ==================================================
    // Widths and operation codes
    // ==================================================
    localparam int csr_addr_w = 12;
    localparam int xlen       = 32;

    // Code 00 is no operation
    localparam logic [1:0] csr_op_write = 2'b01;
    localparam logic [1:0] csr_op_set   = 2'b10;
    localparam logic [1:0] csr_op_clear = 2'b11;

    // Top two address bits set means read-only space
    localparam logic [1:0] csr_access_ro = 2'b11;

    // ==================================================
    // Machine CSR addresses
    // ==================================================
    localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mie       = 12'h304;
    localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mscratch  = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mtval     = 12'h343;
    localparam logic [csr_addr_w-1:0] csr_mcycle    = 12'hB00;
    localparam logic [csr_addr_w-1:0] csr_minstret  = 12'hB02;
    localparam logic [csr_addr_w-1:0] csr_mcycleh   = 12'hB80;
    localparam logic [csr_addr_w-1:0] csr_minstreth = 12'hB82;

    // Exception codes written to mcause
    localparam logic [xlen-1:0] cause_illegal_instruction = 32'd2;
    localparam logic [xlen-1:0] cause_breakpoint          = 32'd3;
    localparam logic [xlen-1:0] cause_misaligned_access   = 32'd4;
    localparam logic [xlen-1:0] cause_illegal_csr_access  = 32'd11;

    // ==================================================
    // Types
    // ==================================================
    typedef struct packed {
        logic [1:0] access;
        logic [1:0] privilege;
        logic [7:0] index;
    } t_csr_addr_fields;

    // Same 12 bits, seen as a flat address or by field
    typedef union packed {
        logic [csr_addr_w-1:0] raw;
        t_csr_addr_fields      fields;
    } t_csr_addr;

    typedef struct packed {
        logic            wren;
        logic            rden;
        logic [1:0]      op;
        t_csr_addr       addr;
        logic [xlen-1:0] imm;
        logic            imm_sel;
    } t_csr_inst;

    typedef struct packed {
        logic                  en;
        logic [1:0]            op;
        logic [csr_addr_w-1:0] addr;
        logic [xlen-1:0]       operand;
    } t_csr_write_req;

    typedef struct packed {
        logic            hit;
        logic [xlen-1:0] data;
    } t_csr_read_rsp;

    typedef struct packed {
        logic illegal_instruction;
        logic misaligned_access;
        logic illegal_csr_access;
        logic breakpoint;
        logic external_interrupt;
        logic timer_interrupt;
        logic mret;
    } t_trap_event;

    typedef struct packed {
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mepc;
    } t_trap_vectors;

    typedef struct packed {
        logic            jump_en;
        logic [xlen-1:0] jump_addr;
        logic            return_en;
        logic [xlen-1:0] return_addr;
    } t_pc_update;

    // Write, set or clear applied to one register word
    function automatic logic [xlen-1:0] csr_apply(
        input logic [1:0]      op,
        input logic [xlen-1:0] cur,
        input logic [xlen-1:0] operand
    );
        logic [xlen-1:0] result;
        case (op)
            csr_op_write: result = operand;
            csr_op_set:   result = cur | operand;
            csr_op_clear: result = cur & ~operand;
            default:      result = cur;
        endcase
        return result;
    endfunction

endpackage

// File: source/csr_response.sv
`timescale 1ns/1ps

module csr_response (
    input  logic                            rden,
    input  csr_pkg::t_csr_read_rsp          counter_rsp,
    input  csr_pkg::t_csr_read_rsp          trap_rsp,
    input  csr_pkg::t_trap_event            trap,
    input  csr_pkg::t_trap_vectors          vectors,
    output logic [csr_pkg::xlen-1:0]        read_data,
    output csr_pkg::t_pc_update             pc_update
);
    import csr_pkg::*;

    logic begin_trap;

    // ==================================================
    // Read data merge
    // ==================================================
    // Address ranges are disjoint so at most one bank hits
    always_comb begin
        read_data = '0;
        if (rden) begin
            if (trap_rsp.hit) begin
                read_data = trap_rsp.data;
            end else if (counter_rsp.hit) begin
                read_data = counter_rsp.data;
            end
        end
    end

    // ==================================================
    // Fetch redirect
    // ==================================================
    // Exceptions and both interrupt sources enter the handler
    assign begin_trap = trap.illegal_instruction || trap.misaligned_access ||
                        trap.illegal_csr_access || trap.breakpoint ||
                        trap.external_interrupt || trap.timer_interrupt;

    always_comb begin
        pc_update.jump_en     = begin_trap;
        pc_update.jump_addr   = vectors.mtvec;
        pc_update.return_en   = trap.mret;
        pc_update.return_addr = vectors.mepc;
    end

endmodule

// File: source/csr_trap_bank.sv
`timescale 1ns/1ps

module csr_trap_bank (
    input  logic                            clk,
    input  logic                            rst,
    input  csr_pkg::t_csr_write_req         write_req,
    input  logic [csr_pkg::csr_addr_w-1:0]  read_addr,
    input  logic [csr_pkg::xlen-1:0]        pc,
    input  csr_pkg::t_trap_event            trap,
    output csr_pkg::t_csr_read_rsp          read_rsp,
    output csr_pkg::t_trap_vectors          vectors
);
    import csr_pkg::*;

    // Trap setup
    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mtvec;
    // Trap handling
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;

    logic            exception;
    logic [xlen-1:0] exc_cause;

    // ==================================================
    // Exception detect and cause priority
    // ==================================================
    assign exception = trap.breakpoint || trap.illegal_csr_access ||
                       trap.misaligned_access || trap.illegal_instruction;

    always_comb begin
        if (trap.breakpoint) begin
            exc_cause = cause_breakpoint;
        end else if (trap.illegal_csr_access) begin
            exc_cause = cause_illegal_csr_access;
        end else if (trap.misaligned_access) begin
            exc_cause = cause_misaligned_access;
        end else begin
            exc_cause = cause_illegal_instruction;
        end
    end

    // ==================================================
    // Register update
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            if (write_req.en) begin
                case (write_req.addr)
                    csr_mstatus:  mstatus  <= csr_apply(write_req.op, mstatus, write_req.operand);
                    csr_mie:      mie      <= csr_apply(write_req.op, mie, write_req.operand);
                    csr_mtvec:    mtvec    <= csr_apply(write_req.op, mtvec, write_req.operand);
                    csr_mscratch: mscratch <= csr_apply(write_req.op, mscratch, write_req.operand);
                    csr_mepc:     mepc     <= csr_apply(write_req.op, mepc, write_req.operand);
                    csr_mcause:   mcause   <= csr_apply(write_req.op, mcause, write_req.operand);
                    csr_mtval:    mtval    <= csr_apply(write_req.op, mtval, write_req.operand);
                    default: ;
                endcase
            end
            // Hardware capture comes last so it overrides a software write
            if (exception) begin
                mepc   <= pc;
                mcause <= exc_cause;
            end
        end
    end

    // ==================================================
    // Read port and vectors
    // ==================================================
    always_comb begin
        read_rsp.hit = 1'b1;
        case (read_addr)
            csr_mstatus:  read_rsp.data = mstatus;
            csr_mie:      read_rsp.data = mie;
            csr_mtvec:    read_rsp.data = mtvec;
            csr_mscratch: read_rsp.data = mscratch;
            csr_mepc:     read_rsp.data = mepc;
            csr_mcause:   read_rsp.data = mcause;
            csr_mtval:    read_rsp.data = mtval;
            default: begin
                read_rsp.hit  = 1'b0;
                read_rsp.data = '0;
            end
        endcase
    end

    assign vectors.mtvec = mtvec;
    assign vectors.mepc  = mepc;

endmodule

// File: verification/csr_file_assertions.sv
`timescale 1ns/1ps

module csr_file_assertions (
    input logic                     clk,
    input logic                     rst,
    input csr_pkg::t_csr_inst       csr_inst,
    input csr_pkg::t_trap_event     trap,
    input logic [csr_pkg::xlen-1:0] read_data,
    input csr_pkg::t_pc_update      pc_update
);
    // Number of assertion failures so far
    int   fail_count = 0;
    logic any_trap;

    // Exceptions and both interrupts enter the handler
    assign any_trap = trap.illegal_instruction || trap.misaligned_access ||
                      trap.illegal_csr_access || trap.breakpoint ||
                      trap.external_interrupt || trap.timer_interrupt;

    jump_matches_flags: assert property (@(posedge clk) disable iff (rst)
        pc_update.jump_en == any_trap)
        else begin
            fail_count++;
            $error("jump_en does not match the trap flags");
        end

    read_zero_when_idle: assert property (@(posedge clk) disable iff (rst)
        !csr_inst.rden |-> read_data == '0)
        else begin
            fail_count++;
            $error("read_data is not zero while rden is low");
        end

    return_follows_mret: assert property (@(posedge clk) disable iff (rst)
        pc_update.return_en == trap.mret)
        else begin
            fail_count++;
            $error("return_en does not follow mret");
        end

endmodule

// File: verification/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;
    import csr_pkg::*;

    localparam int max_cycles = 2000;
    localparam logic [csr_addr_w-1:0] trap_addrs [7] = '{csr_mstatus, csr_mie, csr_mtvec,
        csr_mscratch, csr_mepc, csr_mcause, csr_mtval};

    logic            clk = 1'b0;
    logic            rst;
    t_csr_inst       csr_inst;
    logic [xlen-1:0] write_data;
    logic [xlen-1:0] pc;
    t_trap_event     trap;
    logic            instret_valid;
    logic [xlen-1:0] read_data;
    t_pc_update      pc_update;

    integer seed        = 32'hb0c6;
    int     error_count = 0;
    int     cycle_count = 0;

    // Reference model of the trap bank by address and the counters as 64 bits
    logic [xlen-1:0] m_regs [logic [csr_addr_w-1:0]];
    logic [63:0]     m_mcycle;
    logic [63:0]     m_minstret;

    csr_file i_csr_file (
        .clk           (clk),
        .rst           (rst),
        .csr_inst      (csr_inst),
        .write_data    (write_data),
        .pc            (pc),
        .trap          (trap),
        .instret_valid (instret_valid),
        .read_data     (read_data),
        .pc_update     (pc_update)
    );

    bind csr_file csr_file_assertions i_csr_file_assertions (
        .clk       (clk),
        .rst       (rst),
        .csr_inst  (csr_inst),
        .trap      (trap),
        .read_data (read_data),
        .pc_update (pc_update)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [xlen-1:0] apply_op(input logic [1:0] op,
                                                 input logic [xlen-1:0] cur,
                                                 input logic [xlen-1:0] val);
        case (op)
            csr_op_write: return val;
            csr_op_set:   return cur | val;
            csr_op_clear: return cur & ~val;
            default:      return cur;
        endcase
    endfunction

    function automatic logic [xlen-1:0] model_read(input logic [csr_addr_w-1:0] addr);
        case (addr)
            csr_mcycle:    return m_mcycle[31:0];
            csr_mcycleh:   return m_mcycle[63:32];
            csr_minstret:  return m_minstret[31:0];
            csr_minstreth: return m_minstret[63:32];
            default:       return m_regs.exists(addr) ? m_regs[addr] : '0;
        endcase
    endfunction

    function automatic t_pc_update expected_pc_update();
        t_pc_update exp;
        exp.jump_en     = trap.illegal_instruction || trap.misaligned_access ||
                          trap.illegal_csr_access || trap.breakpoint ||
                          trap.external_interrupt || trap.timer_interrupt;
        exp.jump_addr   = m_regs[csr_mtvec];
        exp.return_en   = trap.mret;
        exp.return_addr = m_regs[csr_mepc];
        return exp;
    endfunction

    // One clock edge; the model follows the inputs driven in this cycle
    task automatic tick();
        logic [csr_addr_w-1:0] a;
        logic                  wr;
        logic [xlen-1:0]       opnd;
        logic                  exc;
        logic [xlen-1:0]       cause;
        logic [63:0]           cyc;
        logic [63:0]           ins;
        a     = csr_inst.addr.raw;
        wr    = csr_inst.wren && (a[11:10] != 2'b11);
        opnd  = csr_inst.imm_sel ? csr_inst.imm : write_data;
        exc   = trap.breakpoint || trap.illegal_csr_access ||
                trap.misaligned_access || trap.illegal_instruction;
        cause = trap.breakpoint ? cause_breakpoint :
                trap.illegal_csr_access ? cause_illegal_csr_access :
                trap.misaligned_access ? cause_misaligned_access : cause_illegal_instruction;
        cyc   = m_mcycle + 64'd1;
        ins   = m_minstret + 64'(instret_valid);
        // A software access to one half replaces that half's increment
        if (wr && a == csr_mcycle) begin
            cyc = {m_mcycle[63:32], apply_op(csr_inst.op, m_mcycle[31:0], opnd)};
        end
        if (wr && a == csr_mcycleh) begin
            cyc = {apply_op(csr_inst.op, m_mcycle[63:32], opnd), m_mcycle[31:0] + 32'd1};
        end
        if (wr && a == csr_minstret) begin
            ins = {m_minstret[63:32], apply_op(csr_inst.op, m_minstret[31:0], opnd)};
        end
        if (wr && a == csr_minstreth) begin
            ins = {apply_op(csr_inst.op, m_minstret[63:32], opnd),
                   m_minstret[31:0] + 32'(instret_valid)};
        end
        @(posedge clk);
        if (rst) begin
            foreach (trap_addrs[i]) begin
                m_regs[trap_addrs[i]] = '0;
            end
            m_mcycle   = '0;
            m_minstret = '0;
        end else begin
            if (wr && m_regs.exists(a)) begin
                m_regs[a] = apply_op(csr_inst.op, m_regs[a], opnd);
            end
            if (exc) begin
                m_regs[csr_mepc]   = pc;
                m_regs[csr_mcause] = cause;
            end
            m_mcycle   = cyc;
            m_minstret = ins;
        end
        #1;
    endtask

    // ==================================================
    // Drive and compare
    // ==================================================
    task automatic idle();
        csr_inst      = '0;
        write_data    = '0;
        pc            = '0;
        trap          = '0;
        instret_valid = 1'b0;
    endtask

    // The unused operand source carries noise to catch a wrong select
    task automatic set_inst(input logic wren, input logic rden, input logic [1:0] op,
                            input logic [csr_addr_w-1:0] addr, input logic [xlen-1:0] value,
                            input logic imm_sel);
        csr_inst.wren     = wren;
        csr_inst.rden     = rden;
        csr_inst.op       = op;
        csr_inst.addr.raw = addr;
        csr_inst.imm_sel  = imm_sel;
        csr_inst.imm      = imm_sel ? value : $random(seed);
        write_data        = imm_sel ? $random(seed) : value;
    endtask

    task automatic check_word(input logic [xlen-1:0] exp, input logic [xlen-1:0] act,
                              input string what);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_pc_update(input t_pc_update exp, input t_pc_update act,
                                   input string what);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s expected jump %b/%h return %b/%h, got %b/%h %b/%h",
                     $time, what, exp.jump_en, exp.jump_addr, exp.return_en, exp.return_addr,
                     act.jump_en, act.jump_addr, act.return_en, act.return_addr);
        end
    endtask

    task automatic csr_write(input logic [1:0] op, input logic [csr_addr_w-1:0] addr,
                             input logic [xlen-1:0] value, input logic imm_sel);
        idle();
        set_inst(1'b1, 1'b0, op, addr, value, imm_sel);
        tick();
    endtask

    task automatic read_check(input logic [csr_addr_w-1:0] addr, input logic [xlen-1:0] exp,
                              input string what);
        idle();
        set_inst(1'b0, 1'b1, 2'b00, addr, '0, 1'b0);
        #20;
        check_word(exp, read_data, what);
        tick();
    endtask

    // Drive trap flags for one cycle, then read back mcause and mepc
    task automatic raise_trap(input t_trap_event ev, input logic [xlen-1:0] pc_val,
                              input logic [xlen-1:0] exp_cause,
                              input logic [xlen-1:0] exp_epc, input string what);
        idle();
        trap = ev;
        pc   = pc_val;
        #20;
        check_pc_update(expected_pc_update(), pc_update, what);
        tick();
        read_check(csr_mcause, exp_cause, what);
        read_check(csr_mepc, exp_epc, what);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset();
        foreach (trap_addrs[i]) begin
            read_check(trap_addrs[i], '0, "register after reset");
        end
        idle();
        // mcycle has been counting since reset, so an ungated read shows up
        csr_inst.addr.raw = csr_mcycle;
        #20;
        check_word('0, read_data, "read_data with rden low");
        check_pc_update('0, pc_update, "pc_update after reset");
        tick();
    endtask

    task automatic test_software_access();
        logic [csr_addr_w-1:0] addrs [4];
        logic [csr_addr_w-1:0] a;
        logic [1:0]            op;
        addrs = '{csr_mscratch, csr_mtvec, csr_mie, csr_mstatus};
        repeat (24) begin
            a  = addrs[$unsigned($random(seed)) % 4];
            op = 2'(1 + ($unsigned($random(seed)) % 3));
            csr_write(op, a, $random(seed), 1'($random(seed)));
            read_check(a, model_read(a), "software access readback");
        end
    endtask

    task automatic test_address_filter();
        csr_write(csr_op_write, csr_mscratch, 32'h1234_5678, 1'b0);
        csr_write(csr_op_write, 12'hF14, 32'hFFFF_FFFF, 1'b0);
        csr_write(csr_op_set, 12'hC00, 32'hFFFF_FFFF, 1'b1);
        read_check(csr_mscratch, 32'h1234_5678, "mscratch after read-only writes");
        foreach (trap_addrs[i]) begin
            read_check(trap_addrs[i], model_read(trap_addrs[i]), "register after filter");
        end
        read_check(12'hF14, '0, "read-only address");
        read_check(12'h7C0, '0, "unknown address");
    endtask

    task automatic test_counters();
        logic [xlen-1:0] v;
        v = $random(seed);
        csr_write(csr_op_write, csr_mcycle, v, 1'b0);
        idle();
        repeat (5) begin
            tick();
        end
        read_check(csr_mcycle, v + 32'd5, "mcycle five edges after write");
        read_check(csr_mcycleh, model_read(csr_mcycleh), "mcycleh");
        csr_write(csr_op_write, csr_minstret, 32'hFFFF_FFFF, 1'b0);
        csr_write(csr_op_write, csr_minstreth, 32'h0, 1'b1);
        idle();
        instret_valid = 1'b1;
        tick();
        read_check(csr_minstret, '0, "minstret wrap");
        read_check(csr_minstreth, 32'd1, "minstreth carry");
        idle();
        repeat (3) begin
            tick();
        end
        read_check(csr_minstret, '0, "minstret without retire");
        read_check(csr_minstreth, 32'd1, "minstreth without retire");
    endtask

    task automatic test_traps();
        t_trap_event     ev;
        logic [xlen-1:0] cause_now;
        logic [xlen-1:0] epc_now;
        csr_write(csr_op_write, csr_mtvec, 32'h0000_8000, 1'b0);
        // Flag order is illegal, misaligned, csr access, breakpoint, ext, timer, mret
        raise_trap(7'b1000000, 32'h100, cause_illegal_instruction, 32'h100, "illegal");
        raise_trap(7'b0100000, 32'h104, cause_misaligned_access, 32'h104, "misaligned");
        raise_trap(7'b0010000, 32'h108, cause_illegal_csr_access, 32'h108, "csr access");
        raise_trap(7'b0001000, 32'h10c, cause_breakpoint, 32'h10c, "breakpoint");
        raise_trap(7'b1111000, 32'h110, cause_breakpoint, 32'h110, "all exceptions");
        raise_trap(7'b1110000, 32'h114, cause_illegal_csr_access, 32'h114, "three exceptions");
        raise_trap(7'b1100000, 32'h118, cause_misaligned_access, 32'h118, "two exceptions");
        // Capture beats a software write to mcause on the same edge
        idle();
        set_inst(1'b1, 1'b0, csr_op_write, csr_mcause, 32'h55, 1'b0);
        trap.misaligned_access = 1'b1;
        pc = 32'h200;
        tick();
        read_check(csr_mcause, cause_misaligned_access, "exception over mcause write");
        cause_now = cause_misaligned_access;
        epc_now   = 32'h200;
        ev        = '0;
        ev.external_interrupt = 1'b1;
        raise_trap(ev, 32'h300, cause_now, epc_now, "external interrupt");
        ev        = '0;
        ev.timer_interrupt = 1'b1;
        raise_trap(ev, 32'h304, cause_now, epc_now, "timer interrupt");
        idle();
        trap.mret = 1'b1;
        #20;
        check_pc_update(expected_pc_update(), pc_update, "mret");
        check_word(epc_now, pc_update.return_addr, "mret return address");
        tick();
    endtask

    initial begin
        rst = 1'b1;
        idle();
        repeat (4) begin
            tick();
        end
        rst = 1'b0;
        test_reset();
        test_software_access();
        test_address_filter();
        test_counters();
        test_traps();
        idle();
        tick();
        $display("Summary: %0d check errors, %0d assertion failures", error_count,
                 i_csr_file.i_csr_file_assertions.fail_count);
        if (error_count == 0 && i_csr_file.i_csr_file_assertions.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
